// ==== hw/optics_ctrl_pkg.sv ====
// optics control shared types
// bus, CFP pin and MDIO command structs plus register map constants
`default_nettype none

package optics_ctrl_pkg;

	////////////////////////////////////////
	// status register bus
	////////////////////////////////////////

	typedef struct packed {
		logic [15:0] addr;
		logic        read;
		logic        write;
		logic [31:0] wdata;
	} status_req_t;

	typedef struct packed {
		logic [31:0] rdata;
		logic        valid;	// one cycle per accepted read
	} status_rsp_t;

	////////////////////////////////////////
	// CFP pins, clean and raw
	////////////////////////////////////////

	typedef struct packed {
		logic ic_enable;	// bit 4
		logic prg_power_2;
		logic prg_power_3;
		logic tx_disable;
		logic low_power;	// bit 0
	} cfp_ctrl_t;

	typedef struct packed {
		logic alarm;	// bit 6
		logic ready;
		logic high_power;
		logic cdr_lock;
		logic rx_signal;
		logic present;
		logic in_reset;	// bit 0
	} cfp_stat_t;

	typedef struct packed {
		logic       mod_abs;	// high when no module
		logic       rx_los;
		logic [3:1] prg_alrm;	// MSA numbering starts at 1
		logic       glb_alrm;	// active low
	} cfp_pins_in_t;

	typedef struct packed {
		logic       mod_lopwr;
		logic       mod_rst;	// low holds module in reset
		logic       tx_dis;
		logic [3:1] prg_cntl;
	} cfp_pins_out_t;

	////////////////////////////////////////
	// MDIO host
	////////////////////////////////////////

	typedef enum logic [1:0] {
		op_addr     = 2'b00,
		op_write    = 2'b01,
		op_read_inc = 2'b10,
		op_read     = 2'b11
	} mdio_op_e;

	typedef struct packed {
		logic        start;	// one cycle strobe
		mdio_op_e    op;
		logic [4:0]  prtad;
		logic [4:0]  devad;
		logic [15:0] data;
	} mdio_cmd_t;

	typedef struct packed {
		logic        busy;
		logic        rdata_valid;
		logic [15:0] rdata;
	} mdio_rsp_t;

	// register offsets within the 64 word window
	localparam logic [5:0] REG_ID         = 6'h00;
	localparam logic [5:0] REG_SCRATCH    = 6'h01;
	localparam logic [5:0] REG_ENABLE     = 6'h02;
	localparam logic [5:0] REG_STATUS     = 6'h03;
	localparam logic [5:0] REG_CTRL       = 6'h04;
	localparam logic [5:0] REG_MDIO_WDATA = 6'h10;
	localparam logic [5:0] REG_MDIO_RDATA = 6'h11;
	localparam logic [5:0] REG_MDIO_ADDRS = 6'h12;
	localparam logic [5:0] REG_MDIO_CMD   = 6'h13;

	localparam logic [31:0] ID_WORD       = "OPTs";
	localparam logic [31:0] UNMAPPED_WORD = 32'h0000_0123;

	// ICs enabled, regular power, tx on, full power
	localparam cfp_ctrl_t   CTRL_RESET       = 5'b11100;
	localparam logic [14:0] MDIO_ADDRS_RESET = 15'h0001;	// port 0, device 1

endpackage

`default_nettype wire

// ==== hw/cfp_pin_sync.sv ====
// CFP pin conditioning
// syncs status pins into clean active-high bits, maps control bits onto pins
`timescale 1ns/1ps
`default_nettype none

module cfp_pin_sync (
	input  wire logic                          clk_status,
	input  wire logic                          i_rst_n,
	input  wire optics_ctrl_pkg::cfp_pins_in_t i_pins,
	input  wire optics_ctrl_pkg::cfp_ctrl_t    i_ctrl,
	input  wire logic                          i_enable,
	output optics_ctrl_pkg::cfp_pins_out_t     o_pins,
	output optics_ctrl_pkg::cfp_stat_t         o_stat
);
	import optics_ctrl_pkg::*;

	cfp_stat_t stat_cap;	// first stage, polarity already fixed

	// pin polarities vary per signal, normalize at capture
	always_ff @(posedge clk_status) begin
		if (!i_rst_n) begin
			stat_cap <= '0;
			o_stat   <= '0;
		end else begin
			stat_cap.in_reset   <= ~i_enable;	// module reset pin follows enable
			stat_cap.present    <= ~i_pins.mod_abs;
			stat_cap.rx_signal  <= ~i_pins.rx_los;
			stat_cap.cdr_lock   <= i_pins.prg_alrm[1];
			stat_cap.high_power <= i_pins.prg_alrm[2];
			stat_cap.ready      <= i_pins.prg_alrm[3];
			stat_cap.alarm      <= ~i_pins.glb_alrm;
			o_stat              <= stat_cap;	// second sync stage
		end
	end

	// control side
	assign o_pins.prg_cntl[1] = i_ctrl.ic_enable;
	assign o_pins.prg_cntl[2] = i_ctrl.prg_power_2;
	assign o_pins.prg_cntl[3] = i_ctrl.prg_power_3;
	assign o_pins.tx_dis      = i_ctrl.tx_disable;
	assign o_pins.mod_lopwr   = i_ctrl.low_power;
	assign o_pins.mod_rst     = i_enable;	// active low reset, so 0 holds module

endmodule

`default_nettype wire

// ==== hw/mdio_host.sv ====
// Clause 45 MDIO host
// 64 bit frame engine, MDC divider, tristate enable and read capture
`timescale 1ns/1ps
`default_nettype none

module mdio_host #(
	parameter int MDC_DIV = 500	// clk_status cycles per MDC half period
) (
	input  wire logic                       clk_status,
	input  wire logic                       i_rst_n,
	input  wire optics_ctrl_pkg::mdio_cmd_t i_cmd,
	output optics_ctrl_pkg::mdio_rsp_t      o_rsp,
	output logic                            o_mdc,
	input  wire logic                       i_mdio,
	output logic                            o_mdio,
	output logic                            o_mdio_oe
);
	import optics_ctrl_pkg::*;

	localparam int DIV_W = (MDC_DIV > 1) ? $clog2(MDC_DIV) : 1;

	logic [DIV_W-1:0] div_cnt;
	logic             tick;
	logic             mdc_rise;
	logic             mdc_fall;

	logic [63:0] frame;
	logic        cmd_is_read;
	logic [63:0] tx_sreg;
	logic [15:0] rx_sreg;
	logic [6:0]  fall_cnt;	// frame bits put on the wire so far
	logic        busy;
	logic        started;	// first falling edge of the frame seen
	logic        is_read;
	logic        rd_valid;

	////////////////////////////////////////
	// MDC generation
	////////////////////////////////////////

	assign tick     = (div_cnt == DIV_W'(MDC_DIV - 1));
	assign mdc_rise = tick & ~o_mdc;
	assign mdc_fall = tick & o_mdc;

	// free running, frames line up on the next falling edge
	always_ff @(posedge clk_status) begin
		if (!i_rst_n) begin
			div_cnt <= '0;
			o_mdc   <= 1'b0;
		end else if (tick) begin
			div_cnt <= '0;
			o_mdc   <= ~o_mdc;
		end else begin
			div_cnt <= div_cnt + 1'b1;
		end
	end

	////////////////////////////////////////
	// frame assembly
	////////////////////////////////////////

	assign cmd_is_read = (i_cmd.op == op_read) || (i_cmd.op == op_read_inc);

	always_comb begin
		frame = {32'hffff_ffff,	// preamble
			2'b00,		// ST, clause 45
			i_cmd.op,
			i_cmd.prtad,
			i_cmd.devad,
			cmd_is_read ? 2'b11 : 2'b10,	// TA, 2nd bit released on reads
			cmd_is_read ? 16'hffff : i_cmd.data};
	end

	////////////////////////////////////////
	// frame sequencing
	////////////////////////////////////////

	always_ff @(posedge clk_status) begin
		if (!i_rst_n) begin
			busy      <= 1'b0;
			started   <= 1'b0;
			fall_cnt  <= '0;
			is_read   <= 1'b0;
			rd_valid  <= 1'b0;
			o_mdio_oe <= 1'b0;
		end else begin
			rd_valid <= 1'b0;	// pulse
			if (i_cmd.start) begin
				busy     <= 1'b1;
				started  <= 1'b0;
				fall_cnt <= '0;
				is_read  <= cmd_is_read;
			end else if (busy && mdc_fall) begin
				started <= 1'b1;
				if (fall_cnt == 7'd64) begin
					// last MDC done, close the frame
					busy      <= 1'b0;
					started   <= 1'b0;
					o_mdio_oe <= 1'b0;
					rd_valid  <= is_read;
				end else begin
					fall_cnt  <= fall_cnt + 1'b1;
					// bit 47 is the second TA bit
					o_mdio_oe <= ~(is_read && (fall_cnt >= 7'd47));
				end
			end
		end
	end

	// shift paths
	always_ff @(posedge clk_status) begin
		if (i_cmd.start) begin
			tx_sreg <= frame;
		end else if (busy && mdc_fall) begin
			o_mdio  <= tx_sreg[63];	// msb first
			tx_sreg <= {tx_sreg[62:0], 1'b1};
		end
		if (started && mdc_rise) begin
			rx_sreg <= {rx_sreg[14:0], i_mdio};	// last 16 samples are the data
		end
	end

	assign o_rsp.busy        = busy;
	assign o_rsp.rdata_valid = rd_valid;
	assign o_rsp.rdata       = rx_sreg;

endmodule

`default_nettype wire

// ==== hw/optics_regs.sv ====
// optics control register block
// status bus decode, register file, read mux and MDIO command strobes
`timescale 1ns/1ps
`default_nettype none

module optics_regs #(
	parameter logic [5:0] ADDR_PREFIX = 6'b001000
) (
	input  wire logic                         clk_status,
	input  wire logic                         i_rst_n,
	input  wire optics_ctrl_pkg::status_req_t i_req,
	output optics_ctrl_pkg::status_rsp_t      o_rsp,
	output optics_ctrl_pkg::cfp_ctrl_t        o_ctrl,
	output logic                              o_enable,
	input  wire optics_ctrl_pkg::cfp_stat_t   i_stat,
	output optics_ctrl_pkg::mdio_cmd_t        o_mdio_cmd,
	input  wire optics_ctrl_pkg::mdio_rsp_t   i_mdio_rsp,
	output logic [4:0]                        o_prtadr
);
	import optics_ctrl_pkg::*;

	status_req_t req_r;	// registered request
	logic        sel_r;	// prefix hit
	logic [5:0]  offset;

	logic [31:0] scratch;
	logic [15:0] mdio_wdata;
	logic [15:0] mdio_rdata;	// last completed read
	logic [14:0] mdio_addrs;	// {prtadr, port, device}
	logic [3:0]  cmd_bits;	// {addr, write, read_inc, read}, self clearing
	logic        mdio_busy;
	mdio_op_e    cmd_op;

	logic        rsp_valid;
	logic [31:0] rsp_rdata;

	assign offset = req_r.addr[5:0];
	// a strobe in flight counts as busy, host only flags it a cycle later
	assign mdio_busy = i_mdio_rsp.busy | (|cmd_bits);

	////////////////////////////////////////
	// request capture and decode
	////////////////////////////////////////

	always_ff @(posedge clk_status) begin
		if (!i_rst_n) begin
			req_r <= '0;
			sel_r <= 1'b0;
		end else begin
			req_r <= i_req;
			sel_r <= (i_req.addr[15:6] == {ADDR_PREFIX, 4'h0});
		end
	end

	// control registers
	always_ff @(posedge clk_status) begin
		if (!i_rst_n) begin
			o_ctrl     <= CTRL_RESET;
			o_enable   <= 1'b0;	// module held in reset
			mdio_addrs <= MDIO_ADDRS_RESET;
			cmd_bits   <= '0;
		end else begin
			cmd_bits <= '0;
			if (req_r.write && sel_r) begin
				case (offset)
					REG_ENABLE:     o_enable <= req_r.wdata[0];
					REG_CTRL:       o_ctrl   <= req_r.wdata[4:0];
					REG_MDIO_ADDRS: if (!mdio_busy) mdio_addrs <= req_r.wdata[14:0];
					REG_MDIO_CMD:   if (!mdio_busy) cmd_bits <= req_r.wdata[3:0];
					default:        ;
				endcase
			end
		end
	end

	// data registers
	always_ff @(posedge clk_status) begin
		if (req_r.write && sel_r && offset == REG_SCRATCH)
			scratch <= req_r.wdata;
		if (req_r.write && sel_r && offset == REG_MDIO_WDATA && !mdio_busy)
			mdio_wdata <= req_r.wdata[15:0];
		if (i_mdio_rsp.rdata_valid)
			mdio_rdata <= i_mdio_rsp.rdata;	// hold until next read completes
	end

	////////////////////////////////////////
	// read mux
	////////////////////////////////////////

	always_ff @(posedge clk_status) begin
		if (!i_rst_n) begin
			rsp_valid <= 1'b0;
		end else begin
			rsp_valid <= req_r.read & sel_r;	// other prefixes get no reply
		end
	end

	always_ff @(posedge clk_status) begin
		if (req_r.read && sel_r) begin
			case (offset)
				REG_ID:         rsp_rdata <= ID_WORD;
				REG_SCRATCH:    rsp_rdata <= scratch;
				REG_ENABLE:     rsp_rdata <= {31'b0, o_enable};
				REG_STATUS:     rsp_rdata <= {25'b0, i_stat};
				REG_CTRL:       rsp_rdata <= {27'b0, o_ctrl};
				REG_MDIO_WDATA: rsp_rdata <= {16'b0, mdio_wdata};
				REG_MDIO_RDATA: rsp_rdata <= {i_mdio_rsp.busy, 15'b0, mdio_rdata};
				REG_MDIO_ADDRS: rsp_rdata <= {17'b0, mdio_addrs};
				REG_MDIO_CMD:   rsp_rdata <= {28'b0, cmd_bits};
				default:        rsp_rdata <= UNMAPPED_WORD;
			endcase
		end
	end

	assign o_rsp.valid = rsp_valid;
	assign o_rsp.rdata = rsp_rdata;

	////////////////////////////////////////
	// MDIO command
	////////////////////////////////////////

	// lowest set bit wins
	always_comb begin
		if (cmd_bits[0])
			cmd_op = op_read;
		else if (cmd_bits[1])
			cmd_op = op_read_inc;
		else if (cmd_bits[2])
			cmd_op = op_write;
		else
			cmd_op = op_addr;
	end

	assign o_mdio_cmd.start = |cmd_bits;
	assign o_mdio_cmd.op    = cmd_op;
	assign o_mdio_cmd.prtad = mdio_addrs[9:5];
	assign o_mdio_cmd.devad = mdio_addrs[4:0];
	assign o_mdio_cmd.data  = mdio_wdata;
	assign o_prtadr         = mdio_addrs[14:10];	// usually matches prtad

endmodule

`default_nettype wire

// ==== hw/optics_ctrl_top.sv ====
// optics control top level
// joins the register block, CFP pin conditioning and the MDIO host
`timescale 1ns/1ps
`default_nettype none

module optics_ctrl_top #(
	parameter logic [5:0] ADDR_PREFIX = 6'b001000,	// window 0x2000-0x203f
	parameter int         MDC_DIV     = 500
) (
	input  wire logic                          clk_status,
	input  wire logic                          i_rst_n,
	input  wire optics_ctrl_pkg::status_req_t  i_status_req,
	output optics_ctrl_pkg::status_rsp_t       o_status_rsp,
	input  wire optics_ctrl_pkg::cfp_pins_in_t i_cfp_pins,
	output optics_ctrl_pkg::cfp_pins_out_t     o_cfp_pins,
	output logic                               o_mdc,
	input  wire logic                          i_mdio,
	output logic                               o_mdio,
	output logic                               o_mdio_oe,
	output logic [4:0]                         o_prtadr
);
	import optics_ctrl_pkg::*;

	cfp_ctrl_t cfp_ctrl;
	cfp_stat_t cfp_stat;
	logic      module_enable;
	mdio_cmd_t mdio_cmd;
	mdio_rsp_t mdio_rsp;

	optics_regs #(
		.ADDR_PREFIX(ADDR_PREFIX)
	) i_optics_regs (
		.clk_status(clk_status),
		.i_rst_n   (i_rst_n),
		.i_req     (i_status_req),
		.o_rsp     (o_status_rsp),
		.o_ctrl    (cfp_ctrl),
		.o_enable  (module_enable),
		.i_stat    (cfp_stat),
		.o_mdio_cmd(mdio_cmd),
		.i_mdio_rsp(mdio_rsp),
		.o_prtadr  (o_prtadr)
	);

	cfp_pin_sync i_cfp_pin_sync (
		.clk_status(clk_status),
		.i_rst_n   (i_rst_n),
		.i_pins    (i_cfp_pins),
		.i_ctrl    (cfp_ctrl),
		.i_enable  (module_enable),
		.o_pins    (o_cfp_pins),
		.o_stat    (cfp_stat)
	);

	mdio_host #(
		.MDC_DIV(MDC_DIV)
	) i_mdio_host (
		.clk_status(clk_status),
		.i_rst_n   (i_rst_n),
		.i_cmd     (mdio_cmd),
		.o_rsp     (mdio_rsp),
		.o_mdc     (o_mdc),
		.i_mdio    (i_mdio),
		.o_mdio    (o_mdio),
		.o_mdio_oe (o_mdio_oe)
	);

endmodule

`default_nettype wire

// ==== tests/mdio_phy_model.sv ====
// behavioral Clause 45 MDIO peripheral
// 16 entry register array behind an address pointer, counts frames
`timescale 1ns/1ps
`default_nettype none

module mdio_phy_model (
	input  wire logic i_mdc,
	input  wire logic i_mdio,
	output logic      o_mdio,
	output logic      o_mdio_oe,
	output logic [15:0] o_frame_count
);
	logic [15:0] regs [16];
	logic [15:0] ptr;	// clause 45 address register
	logic [31:0] sreg;
	logic [15:0] rd_word;
	logic [1:0]  op;
	int          ones;	// preamble length seen
	int          k;	// bit index from first ST bit
	logic        in_frame;
	logic        rd_active;

	initial begin
		int i;
		for (i = 0; i < 16; i++)
			regs[i] = {4'hc, 4'(i), ~4'(i), 4'(i)};	// pattern over the whole index
		ptr           = '0;
		sreg          = '0;
		rd_word       = '0;
		op            = '0;
		ones          = 0;
		k             = 0;
		in_frame      = 1'b0;
		rd_active     = 1'b0;
		o_mdio        = 1'b1;
		o_mdio_oe     = 1'b0;
		o_frame_count = '0;
	end

	// sample side
	always @(posedge i_mdc) begin
		if (!in_frame) begin
			if (i_mdio) begin
				ones = (ones < 64) ? ones + 1 : ones;
			end else if (ones >= 32) begin
				in_frame      = 1'b1;	// first ST bit
				k             = 0;
				sreg          = '0;
				o_frame_count = o_frame_count + 1'b1;
			end else begin
				ones = 0;
			end
		end else begin
			k    = k + 1;
			sreg = {sreg[30:0], i_mdio};
			if (k == 13) begin
				op = sreg[11:10];
				if (op[1]) begin	// read or read_inc
					rd_word   = regs[ptr[3:0]];
					rd_active = 1'b1;
				end
			end
			if (k == 31) begin
				case (op)
					2'b00: ptr = sreg[15:0];
					2'b01: regs[ptr[3:0]] = sreg[15:0];
					2'b10: ptr = ptr + 1'b1;	// post increment
					default: ;
				endcase
				in_frame = 1'b0;
				ones     = 0;
			end
		end
	end

	// drive side, TA low then data msb first
	always @(negedge i_mdc) begin
		if (rd_active) begin
			if (k == 14) begin
				o_mdio_oe = 1'b1;
				o_mdio    = 1'b0;
			end else if (k >= 15 && k <= 30) begin
				o_mdio = rd_word[30 - k];
			end else if (k == 31) begin
				o_mdio_oe = 1'b0;
				rd_active = 1'b0;
			end
		end
	end

endmodule

`default_nettype wire

// ==== tests/optics_ctrl_checker.sv ====
// response checker for optics control
// follows the stim file, compares read beats, pins, prtadr and frame count
`timescale 1ns/1ps
`default_nettype none

module optics_ctrl_checker (
	input  wire logic                           clk_status,
	input  wire logic signed [31:0]             i_line_idx,
	input  wire optics_ctrl_pkg::status_rsp_t   i_rsp,
	input  wire optics_ctrl_pkg::cfp_pins_out_t i_pins,
	input  wire logic [4:0]                     i_prtadr,
	input  wire logic [15:0]                    i_frame_count,
	output int                                  o_errors,
	output int                                  o_timeouts,
	output logic                                o_done
);
	import optics_ctrl_pkg::*;

	byte         op_q[$];
	logic [31:0] addr_q[$];
	logic [31:0] exp_q[$];

	task automatic load_expectations();
		int    fd;
		int    n;
		string line;
		byte   op;
		logic [31:0] a, d, e;
		fd = $fopen("tests/optics_ctrl_stim.txt", "r");
		if (fd == 0) begin
			$display("checker could not open the stimulus file");
			o_errors++;
			return;
		end
		while (!$feof(fd)) begin
			line = "";
			n = $fgets(line, fd);
			n = $sscanf(line, "%c %h %h %h", op, a, d, e);
			if (n == 4 && op != "#") begin
				op_q.push_back(op);
				addr_q.push_back(a);
				exp_q.push_back(e);
			end
		end
		$fclose(fd);
	endtask

	// M lines may span a whole MDIO frame
	task automatic wait_for_line(input int k, output logic ok);
		int i;
		ok = 1'b0;
		for (i = 0; i < 3000; i++) begin
			if (i_line_idx == k) begin
				ok = 1'b1;
				break;
			end
			@(posedge clk_status);
		end
		if (!ok) begin
			$display("stimulus line %0d was never driven", k);
			o_timeouts++;
		end
	endtask

	task automatic check_read(input logic [15:0] addr, input logic [31:0] expv);
		int i;
		for (i = 0; i < 10; i++) begin
			@(posedge clk_status);
			if (i_rsp.valid) begin
				if (i_rsp.rdata !== expv) begin
					$display("[FAIL] %0t: read 0x%04h got 0x%08h expected 0x%08h",
						$time, addr, i_rsp.rdata, expv);
					o_errors++;
				end
				return;
			end
		end
		$display("read of 0x%04h got no response within 10 cycles", addr);
		o_timeouts++;
	endtask

	task automatic check_silence(input logic [15:0] addr);
		int i;
		for (i = 0; i < 10; i++) begin
			@(posedge clk_status);
			if (i_rsp.valid) begin
				$display("[FAIL] %0t: read 0x%04h outside the window was answered",
					$time, addr);
				o_errors++;
				return;
			end
		end
	endtask

	// pin levels and prtadr after a write has landed
	task automatic check_outputs(input logic [15:0] addr, input logic [31:0] expv);
		repeat (3) @(posedge clk_status);
		if (addr == 16'h2004 || addr == 16'h2002) begin
			if (i_pins !== expv[5:0]) begin
				$display("[FAIL] %0t: cfp pins 0x%02h expected 0x%02h",
					$time, i_pins, expv[5:0]);
				o_errors++;
			end
		end else if (addr == 16'h2012) begin
			if (i_prtadr !== expv[4:0]) begin
				$display("[FAIL] %0t: prtadr 0x%02h expected 0x%02h",
					$time, i_prtadr, expv[4:0]);
				o_errors++;
			end
		end
	endtask

	initial begin
		int   k;
		logic ok;
		o_errors   = 0;
		o_timeouts = 0;
		o_done     = 1'b0;
		load_expectations();
		for (k = 0; k < op_q.size(); k++) begin
			if (op_q[k] == "P" || op_q[k] == "M")
				continue;	// nothing to compare
			wait_for_line(k, ok);
			if (!ok)
				continue;
			case (op_q[k])
				"R": check_read(addr_q[k][15:0], exp_q[k]);
				"N": check_silence(addr_q[k][15:0]);
				"W": check_outputs(addr_q[k][15:0], exp_q[k]);
				"F": begin
					if (i_frame_count !== exp_q[k][15:0]) begin
						$display("[FAIL] %0t: %0d MDIO frames seen, expected %0d",
							$time, i_frame_count, exp_q[k]);
						o_errors++;
					end
				end
				default: ;
			endcase
		end
		o_done = 1'b1;
	end

endmodule

`default_nettype wire

// ==== tests/tb_optics_ctrl.sv ====
// optics control testbench top
// clock, reset, stim file replay on the status bus and CFP pins
`timescale 1ns/1ps
`default_nettype none

module tb_optics_ctrl;
	import optics_ctrl_pkg::*;

	localparam int MDIO_WAIT_MAX = 2000;	// cycles per M line
	localparam int READ_WINDOW   = 10;

	logic          clk_status;
	logic          i_rst_n;
	status_req_t   i_status_req;
	status_rsp_t   o_status_rsp;
	cfp_pins_in_t  i_cfp_pins;
	cfp_pins_out_t o_cfp_pins;
	logic          o_mdc;
	logic          o_mdio;
	logic          o_mdio_oe;
	logic [4:0]    o_prtadr;

	wire           mdio_line;
	logic          phy_mdio;
	logic          phy_mdio_oe;
	logic [15:0]   phy_frames;

	int            line_idx;	// stim line being driven for the checker
	int            chk_errors;
	int            chk_timeouts;
	logic          chk_done;
	int            tb_errors;
	int            tb_timeouts;

	byte           op_q[$];
	logic [31:0]   addr_q[$];
	logic [31:0]   data_q[$];

	// open drain style bus idling high
	assign mdio_line = o_mdio_oe ? o_mdio : (phy_mdio_oe ? phy_mdio : 1'b1);

	always #5 clk_status = ~clk_status;

	optics_ctrl_top #(
		.ADDR_PREFIX(6'b001000),
		.MDC_DIV    (4)	// short frames
	) i_optics_ctrl_top (
		.clk_status  (clk_status),
		.i_rst_n     (i_rst_n),
		.i_status_req(i_status_req),
		.o_status_rsp(o_status_rsp),
		.i_cfp_pins  (i_cfp_pins),
		.o_cfp_pins  (o_cfp_pins),
		.o_mdc       (o_mdc),
		.i_mdio      (mdio_line),
		.o_mdio      (o_mdio),
		.o_mdio_oe   (o_mdio_oe),
		.o_prtadr    (o_prtadr)
	);

	mdio_phy_model i_mdio_phy_model (
		.i_mdc        (o_mdc),
		.i_mdio       (mdio_line),
		.o_mdio       (phy_mdio),
		.o_mdio_oe    (phy_mdio_oe),
		.o_frame_count(phy_frames)
	);

	optics_ctrl_checker i_optics_ctrl_checker (
		.clk_status   (clk_status),
		.i_line_idx   (line_idx),
		.i_rsp        (o_status_rsp),
		.i_pins       (o_cfp_pins),
		.i_prtadr     (o_prtadr),
		.i_frame_count(phy_frames),
		.o_errors     (chk_errors),
		.o_timeouts   (chk_timeouts),
		.o_done       (chk_done)
	);

	////////////////////////////////////////
	// helpers
	////////////////////////////////////////

	task automatic load_stim();
		int    fd;
		int    n;
		string line;
		byte   op;
		logic [31:0] a, d, e;
		fd = $fopen("tests/optics_ctrl_stim.txt", "r");
		if (fd == 0) begin
			$display("could not open the stimulus file");
			tb_errors++;
			return;
		end
		while (!$feof(fd)) begin
			line = "";
			n = $fgets(line, fd);
			n = $sscanf(line, "%c %h %h %h", op, a, d, e);
			if (n == 4 && op != "#") begin	// skip comments and blanks
				op_q.push_back(op);
				addr_q.push_back(a);
				data_q.push_back(d);
			end
		end
		$fclose(fd);
	endtask

	// one cycle request then back to idle
	task automatic issue_req(input int k, input logic [15:0] addr, input logic rd,
			input logic wr, input logic [31:0] wdata);
		status_req_t r;
		r.addr  = addr;
		r.read  = rd;
		r.write = wr;
		r.wdata = wdata;
		@(posedge clk_status);
		i_status_req <= r;
		line_idx     <= k;
		@(posedge clk_status);
		i_status_req <= '0;
	endtask

	task automatic wait_read_beat();
		int i;
		for (i = 0; i < READ_WINDOW; i++) begin
			@(posedge clk_status);
			if (o_status_rsp.valid)
				break;
		end
		@(posedge clk_status);	// gap before next request
	endtask

	task automatic wait_mdio_idle();
		int i;
		for (i = 0; i < MDIO_WAIT_MAX; i++) begin
			@(posedge clk_status);
			if (!i_optics_ctrl_top.mdio_rsp.busy)
				break;
		end
		if (i == MDIO_WAIT_MAX) begin
			$display("MDIO host still busy after %0d cycles at %0t", MDIO_WAIT_MAX, $time);
			tb_timeouts++;
		end
	endtask

	////////////////////////////////////////
	// main sequence
	////////////////////////////////////////

	initial begin
		int k;
		int i;
		clk_status   = 1'b0;
		i_rst_n      = 1'b0;
		i_status_req = '0;
		i_cfp_pins   = 6'b110001;	// no module, los, glb alarm idle high
		line_idx     = -1;
		tb_errors    = 0;
		tb_timeouts  = 0;
		load_stim();
		repeat (16) @(posedge clk_status);
		i_rst_n <= 1'b1;
		repeat (2) @(posedge clk_status);

		for (k = 0; k < op_q.size(); k++) begin
			case (op_q[k])
				"W": begin
					issue_req(k, addr_q[k][15:0], 1'b0, 1'b1, data_q[k]);
					repeat (3) @(posedge clk_status);	// write lands and pins settle
				end
				"R": begin
					issue_req(k, addr_q[k][15:0], 1'b1, 1'b0, '0);
					wait_read_beat();
				end
				"N": begin
					issue_req(k, addr_q[k][15:0], 1'b1, 1'b0, '0);
					repeat (READ_WINDOW) @(posedge clk_status);
				end
				"P": begin
					@(posedge clk_status);
					i_cfp_pins <= data_q[k][5:0];
					line_idx   <= k;
					repeat (4) @(posedge clk_status);	// capture, sync, out reg
				end
				"M": begin
					@(posedge clk_status);
					line_idx <= k;
					wait_mdio_idle();
				end
				"F": begin
					@(posedge clk_status);
					line_idx <= k;
					repeat (2) @(posedge clk_status);
				end
				default: begin
					$display("unknown operation on stimulus line %0d", k);
					tb_errors++;
				end
			endcase
		end

		// let the checker catch up
		for (i = 0; i < 100; i++) begin
			if (chk_done)
				break;
			@(posedge clk_status);
		end
		if (!chk_done) begin
			$display("checker did not finish its expectations");
			tb_timeouts++;
		end

		$display("errors=%0d timeouts=%0d", tb_errors + chk_errors, tb_timeouts + chk_timeouts);
		if (tb_errors + chk_errors == 0 && tb_timeouts + chk_timeouts == 0 && op_q.size() > 0) begin
			$display("RESULT: PASS");
		end else begin
			$display("RESULT: FAIL");
		end
		$finish;
	end

endmodule

`default_nettype wire

// ==== tests/optics_ctrl_stim.txt ====
# columns: op address data expected, all hex
# op W write, R read, N read with no reply, P input pins, M wait MDIO idle, F frame count
R 2000 0 4F505473
R 2004 0 1C
R 2002 0 0
W 2004 1C 07
W 2001 CAFEF00D 0
R 2001 0 CAFEF00D
N 6001 0 0
N 2401 0 0
W 6001 12345678 0
R 2001 0 CAFEF00D
R 2020 0 123
W 2004 03 28
W 2002 1 38
W 2004 14 15
R 2002 0 1
P 0 0B 0
R 2003 0 2E
P 0 0A 0
R 2003 0 6E
W 2012 2861 0A
R 2012 0 2861
W 2010 5 0
W 2013 8 0
M 0 0 0
W 2010 BEEF 0
W 2013 4 0
M 0 0 0
W 2010 5 0
W 2013 8 0
M 0 0 0
W 2013 1 0
M 0 0 0
R 2011 0 BEEF
W 2010 6 0
W 2013 8 0
M 0 0 0
W 2013 2 0
M 0 0 0
R 2011 0 C696
W 2013 2 0
M 0 0 0
R 2011 0 C787
F 0 0 7
W 2010 1111 0
W 2013 8 0
W 2010 2222 0
W 2013 4 0
R 2013 0 0
M 0 0 0
R 2010 0 1111
F 0 0 8

// ==== optics_ctrl.f ====
hw/optics_ctrl_pkg.sv
hw/cfp_pin_sync.sv
hw/mdio_host.sv
hw/optics_regs.sv
hw/optics_ctrl_top.sv
tests/mdio_phy_model.sv
tests/optics_ctrl_checker.sv
tests/tb_optics_ctrl.sv

// ==== Bender.yml ====
package:
  name: optics_ctrl

sources:
  - files:
      - hw/optics_ctrl_pkg.sv
      - hw/cfp_pin_sync.sv
      - hw/mdio_host.sv
      - hw/optics_regs.sv
      - hw/optics_ctrl_top.sv
  - target: test
    files:
      - tests/mdio_phy_model.sv
      - tests/optics_ctrl_checker.sv
      - tests/tb_optics_ctrl.sv
